// File: design/obi_pkg.sv
// Shared types for the load/store data path
// Core requests, OBI-style data bus transfers, responses and buffer state
package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Byte address width on both the core side and the bus side
  localparam int unsigned ADDR_W = 32;
  // Data word width, four byte lanes
  localparam int unsigned DATA_W = 32;

  //////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////

  // Access size as issued by the core
  typedef enum logic [1:0] {
    LSU_BYTE,
    LSU_HALF,
    LSU_WORD
  } lsu_size_e;

  // One-entry write buffer occupancy
  typedef enum logic {
    WBUF_EMPTY,
    WBUF_FULL
  } wbuf_state_e;

  //////////////////////////////////////////////////////////////////////
  // Structures
  //////////////////////////////////////////////////////////////////////

  // Core-side request, store data sits in the low bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    lsu_size_e         size;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  // Bus transfer with word address, byte enables and lane-aligned data
  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                we;
    logic [DATA_W/8-1:0] be;
    logic [DATA_W-1:0]   wdata;
    logic                bufferable;
  } obi_data_req_t;

  // Bus response, we tells a store acknowledge from load data
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              we;
  } obi_data_resp_t;

endpackage

// File: design/lsu_req_stage.sv
// Load/store request stage
// Registers core requests and turns them into aligned bus transfers
`timescale 1ns/1ps

module lsu_req_stage #(
  parameter logic [obi_pkg::ADDR_W-1:0] BUF_BASE = '0,
  parameter logic [obi_pkg::ADDR_W-1:0] BUF_SIZE = 'h200
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core side
  input  logic                   core_valid_i,
  output logic                   core_ready_o,
  input  obi_pkg::lsu_req_t      core_req_i,
  // Towards the write buffer
  output logic                   stg_valid_o,
  input  logic                   stg_ready_i,
  output obi_pkg::obi_data_req_t stg_trans_o
);
  import obi_pkg::*;

  // Holding register, only the valid flag is control state
  logic          valid_q;
  obi_data_req_t trans_q;

  // Transfer formed from the incoming request
  obi_data_req_t trans_d;
  logic [1:0]    byte_ofs;
  logic          in_region;
  logic          accept;

  //////////////////////////////////////////////////////////////////////
  // Transfer formation
  //////////////////////////////////////////////////////////////////////

  assign byte_ofs = core_req_i.addr[1:0];

  // Region check written as an offset compare so base plus size cannot wrap
  assign in_region = (core_req_i.addr >= BUF_BASE) &&
                     ((core_req_i.addr - BUF_BASE) < BUF_SIZE);

  always_comb begin
    trans_d = '0;
    // The bus only sees word addresses, the lane comes from the enables
    trans_d.addr = {core_req_i.addr[ADDR_W-1:2], 2'b00};
    trans_d.we   = core_req_i.we;

    // Byte enables follow size and the offset inside the word
    // Misaligned halfwords never reach this point
    case (core_req_i.size)
      LSU_BYTE: trans_d.be = 4'b0001 << byte_ofs;
      LSU_HALF: trans_d.be = 4'b0011 << byte_ofs;
      default:  trans_d.be = 4'b1111;
    endcase

    // Move the right-aligned store data up into its byte lanes
    trans_d.wdata = core_req_i.wdata << {byte_ofs, 3'b000};

    // Only stores may be posted, a load always has to reach memory
    trans_d.bufferable = core_req_i.we && in_region;
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake and register
  //////////////////////////////////////////////////////////////////////

  // Take a new request when empty or when the current one leaves now
  assign core_ready_o = !valid_q || stg_ready_i;
  assign accept       = core_valid_i && core_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (core_ready_o) begin
      // Either refilled or drained, a held transfer is never dropped
      valid_q <= core_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      trans_q <= trans_d;
    end
  end

  // Payload stays put while the buffer holds off, as the bus rule needs
  assign stg_valid_o = valid_q;
  assign stg_trans_o = trans_q;

endmodule

// File: design/write_buffer.sv
// One-entry write buffer on the data bus
// Posts bufferable stores while the bus stalls, passes everything else through
`timescale 1ns/1ps

module write_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  // From the request stage
  input  logic                   valid_i,
  output logic                   ready_o,
  input  obi_pkg::obi_data_req_t trans_i,
  // Towards the bus
  output logic                   valid_o,
  input  logic                   ready_i,
  output obi_pkg::obi_data_req_t trans_o
);
  import obi_pkg::*;

  wbuf_state_e   state;
  wbuf_state_e   state_next;
  // Posted store, a payload register without reset
  obi_data_req_t trans_q;
  // An offered transfer that may be posted
  logic          bufferable;
  logic          capture;

  assign bufferable = valid_i && trans_i.bufferable;

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    capture    = 1'b0;
    valid_o    = valid_i;
    trans_o    = trans_i;
    ready_o    = ready_i;

    case (state)
      WBUF_EMPTY: begin
        // Pass-through, a bufferable store is always taken
        ready_o = bufferable ? 1'b1 : ready_i;
        if (bufferable && !ready_i) begin
          // Bus is busy, so park the store and free the stage
          capture    = 1'b1;
          state_next = WBUF_FULL;
        end
      end
      WBUF_FULL: begin
        // The posted store goes out first
        valid_o = 1'b1;
        trans_o = trans_q;
        // Loads and unbufferable stores wait for the entry to drain
        ready_o = bufferable && ready_i;
        if (ready_i) begin
          if (bufferable) begin
            // Swap in the next store in the same cycle
            capture = 1'b1;
          end else begin
            state_next = WBUF_EMPTY;
          end
        end
      end
      default: begin
        state_next = WBUF_EMPTY;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WBUF_EMPTY;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      trans_q <= trans_i;
    end
  end

endmodule

// File: design/data_mem.sv
// Data memory slave on the OBI-style bus
// Byte-enable writes and in-order responses one cycle after each accept
`timescale 1ns/1ps

module data_mem #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Address phase
  input  logic                    valid_i,
  output logic                    ready_o,
  input  obi_pkg::obi_data_req_t  trans_i,
  // Outside contention on the bus
  input  logic                    stall_i,
  // Response phase, the core must always take it
  output logic                    rvalid_o,
  output obi_pkg::obi_data_resp_t resp_o
);
  import obi_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // Word array, written by the testbench before any read
  logic [DATA_W-1:0] mem [MEM_WORDS];

  logic             accept;
  logic [IDX_W-1:0] word_idx;

  // Response register and its flag
  logic             rvalid_q;
  obi_data_resp_t   resp_q;

  // Stall alone decides the address phase
  assign ready_o = !stall_i;
  assign accept  = valid_i && ready_o;

  // Word address wraps at the array depth
  assign word_idx = IDX_W'((trans_i.addr >> 2) % MEM_WORDS);

  //////////////////////////////////////////////////////////////////////
  // Array write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept && trans_i.we) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (trans_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= trans_i.wdata[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  // The read samples the word before a write on the same edge lands
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_q.rdata <= mem[word_idx];
      resp_q.we    <= trans_i.we;
    end
  end

  assign rvalid_o = rvalid_q;
  assign resp_o   = resp_q;

endmodule

// File: design/data_port_top.sv
// Data port top level
// Request stage, write buffer and data memory chained on valid/ready links
`timescale 1ns/1ps

module data_port_top #(
  parameter logic [obi_pkg::ADDR_W-1:0] BUF_BASE  = '0,
  parameter logic [obi_pkg::ADDR_W-1:0] BUF_SIZE  = 'h200,
  parameter int unsigned                MEM_WORDS = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Core request link
  input  logic                    core_valid_i,
  output logic                    core_ready_o,
  input  obi_pkg::lsu_req_t       core_req_i,
  // Bus contention from outside
  input  logic                    mem_stall_i,
  // Responses back to the core
  output logic                    rvalid_o,
  output obi_pkg::obi_data_resp_t resp_o
);
  import obi_pkg::*;

  // Stage to buffer link
  logic          stg_valid;
  logic          stg_ready;
  obi_data_req_t stg_trans;

  // Buffer to memory link, the data bus proper
  logic          bus_valid;
  logic          bus_ready;
  obi_data_req_t bus_trans;

  lsu_req_stage #(
    .BUF_BASE (BUF_BASE),
    .BUF_SIZE (BUF_SIZE)
  ) u_req_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_valid_i (core_valid_i),
    .core_ready_o (core_ready_o),
    .core_req_i   (core_req_i),
    .stg_valid_o  (stg_valid),
    .stg_ready_i  (stg_ready),
    .stg_trans_o  (stg_trans)
  );

  write_buffer u_write_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (stg_valid),
    .ready_o (stg_ready),
    .trans_i (stg_trans),
    .valid_o (bus_valid),
    .ready_i (bus_ready),
    .trans_o (bus_trans)
  );

  data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (bus_valid),
    .ready_o  (bus_ready),
    .trans_i  (bus_trans),
    .stall_i  (mem_stall_i),
    .rvalid_o (rvalid_o),
    .resp_o   (resp_o)
  );

endmodule

// File: sim/write_buffer_sva.sv
// Protocol and buffering checks for the one-entry write buffer
`timescale 1ns/1ps

module write_buffer_sva (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   valid_i,
  input logic                   ready_o,
  input obi_pkg::obi_data_req_t trans_i,
  input logic                   valid_o,
  input logic                   ready_i,
  input obi_pkg::obi_data_req_t trans_o,
  input obi_pkg::wbuf_state_e   state,
  input obi_pkg::obi_data_req_t trans_q,
  input logic                   bufferable
);
  import obi_pkg::*;

  // The two cases where a store is parked in the entry
  logic capture_cond;

  assign capture_cond = bufferable &&
                        ((state == WBUF_EMPTY && !ready_i) || (state == WBUF_FULL && ready_i));

  //////////////////////////////////////////////////////////////////////
  // Waited address phases on both sides
  //////////////////////////////////////////////////////////////////////

  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_o |=> valid_i && $stable(trans_i))
    else $error("Stage side dropped or changed a waited transfer");

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> valid_o && $stable(trans_o))
    else $error("Bus side dropped or changed a waited transfer");

  //////////////////////////////////////////////////////////////////////
  // Entry capture
  //////////////////////////////////////////////////////////////////////

  a_capture: assert property (@(posedge clk) disable iff (!rst_n)
    capture_cond |=> state == WBUF_FULL && trans_q == $past(trans_i))
    else $error("Bufferable store was not captured");

  // A full entry only changes through a swap
  a_keep: assert property (@(posedge clk) disable iff (!rst_n)
    state == WBUF_FULL && !capture_cond |=> $stable(trans_q))
    else $error("Buffered store changed without a capture");

  //////////////////////////////////////////////////////////////////////
  // Output source and ready rules
  //////////////////////////////////////////////////////////////////////

  a_full_out: assert property (@(posedge clk) disable iff (!rst_n)
    state == WBUF_FULL |-> valid_o && trans_o == trans_q)
    else $error("Full buffer does not present its entry");

  a_empty_out: assert property (@(posedge clk) disable iff (!rst_n)
    state == WBUF_EMPTY |-> valid_o == valid_i && trans_o === trans_i)
    else $error("Empty buffer is not a pass-through");

  a_ready_empty: assert property (@(posedge clk) disable iff (!rst_n)
    state == WBUF_EMPTY |-> ready_o == (bufferable || ready_i))
    else $error("Ready rule broken in the empty state");

  a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
    state == WBUF_FULL |-> ready_o == (bufferable && ready_i))
    else $error("Ready rule broken in the full state");

endmodule

// File: sim/tb_data_port.sv
// Testbench for the data port
// Directed load/store tests checked against a byte-level reference memory
`timescale 1ns/1ps

module tb_data_port;
  import obi_pkg::*;

  localparam int MEM_WORDS      = 256;
  // Roughly four times the length of all tests together
  localparam int TIMEOUT_CYCLES = 2000;

  logic           clk;
  logic           rst_n;
  logic           core_valid_i;
  logic           core_ready_o;
  lsu_req_t       core_req_i;
  logic           mem_stall_i;
  logic           rvalid_o;
  obi_data_resp_t resp_o;

  // One reference byte per DUT byte, updated in program order
  logic [7:0]     ref_mem [MEM_WORDS*4];
  // Responses the core expects are appended when a request is accepted
  obi_data_resp_t exp_q [$];
  obi_data_resp_t exp_r;
  int             cycle_count  = 0;
  integer         seed         = 90762;
  logic [127:0]   stall_pattern;
  logic           stall_done;
  string          cur_test;

  data_port_top #(
    .BUF_BASE  (32'h0000_0000),
    .BUF_SIZE  (32'h0000_0200),
    .MEM_WORDS (MEM_WORDS)
  ) u_data_port_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_valid_i (core_valid_i),
    .core_ready_o (core_ready_o),
    .core_req_i   (core_req_i),
    .mem_stall_i  (mem_stall_i),
    .rvalid_o     (rvalid_o),
    .resp_o       (resp_o)
  );

  bind write_buffer write_buffer_sva u_wbuf_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .trans_i    (trans_i),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .trans_o    (trans_o),
    .state      (state),
    .trans_q    (trans_q),
    .bufferable (bufferable)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Check failed in %s", test_name);
    end
  endtask

  // Called one half period before the accepting edge
  function automatic void note_accept(input lsu_req_t req);
    int             base;
    int             ofs;
    int             nbytes;
    obi_data_resp_t exp;
    base   = int'((req.addr >> 2) % MEM_WORDS) * 4;
    ofs    = int'(req.addr[1:0]);
    nbytes = (req.size == LSU_BYTE) ? 1 : (req.size == LSU_HALF) ? 2 : 4;
    // A store answers with the word as it stood before the write
    exp.rdata = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    exp.we    = req.we;
    if (req.we) begin
      for (int i = 0; i < nbytes; i++) begin
        ref_mem[base + ofs + i] = req.wdata[8*i +: 8];
      end
    end
    exp_q.push_back(exp);
  endfunction

  // Responses are sampled mid-cycle, well away from the register updates
  always @(negedge clk) begin
    if (rst_n && rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived in %s with no request outstanding", cur_test);
        $display("SIMULATION FAILED");
        $fatal(1, "Unexpected response");
      end else begin
        exp_r = exp_q.pop_front();
        check_value({cur_test, " we"}, 32'(exp_r.we), 32'(resp_o.we));
        check_value({cur_test, " rdata"}, exp_r.rdata, resp_o.rdata);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout in %s after %0d cycles", cur_test, cycle_count);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Holds the current request until the DUT takes it
  task automatic wait_accept(input lsu_req_t req);
    @(negedge clk);
    while (!core_ready_o) @(negedge clk);
    note_accept(req);
    @(posedge clk);
    #2;
  endtask

  task automatic issue(input logic we, input lsu_size_e size, input logic [31:0] addr,
                       input logic [31:0] data);
    lsu_req_t req;
    req.addr     = addr;
    req.we       = we;
    req.size     = size;
    req.wdata    = data;
    core_req_i   = req;
    core_valid_i = 1'b1;
    wait_accept(req);
    core_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (exp_q.size() != 0) @(posedge clk);
    #2;
  endtask

  // Toggles the stall or plays the pattern until the request side is done
  task automatic drive_stall(input logic use_pattern);
    int n;
    n = 0;
    @(posedge clk);
    while (!stall_done) begin
      #2;
      mem_stall_i = use_pattern ? stall_pattern[n % 128] : !mem_stall_i;
      n++;
      @(posedge clk);
    end
    #2;
    mem_stall_i = 1'b0;
  endtask

  // Offers word stores for 10 cycles against a stalled bus
  task automatic offer_under_stall(input logic [31:0] base, input int expected);
    lsu_req_t req;
    int       taken;
    taken        = 0;
    req.addr     = base;
    req.we       = 1'b1;
    req.size     = LSU_WORD;
    req.wdata    = $random(seed);
    mem_stall_i  = 1'b1;
    core_req_i   = req;
    core_valid_i = 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (core_ready_o) begin
        note_accept(req);
        taken++;
        req.addr  = base + 32'(4 * taken);
        req.wdata = $random(seed);
      end
      @(posedge clk);
      #2;
      core_req_i = req;
    end
    check_value({cur_test, " accepted"}, 32'(expected), 32'(taken));
    // Releasing the bus lets the pending store through
    mem_stall_i = 1'b0;
    wait_accept(req);
    core_valid_i = 1'b0;
    wait_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Also fills every word so later reads never see an unwritten array
  task automatic word_roundtrip();
    int w;
    cur_test = "word_roundtrip";
    for (w = 0; w < MEM_WORDS; w++) begin
      issue(1'b1, LSU_WORD, 32'(w * 4), $random(seed));
    end
    for (w = 0; w < MEM_WORDS; w += 8) begin
      issue(1'b0, LSU_WORD, 32'(w * 4), 32'h0);
    end
    wait_idle();
  endtask

  task automatic subword_stores();
    logic [31:0] base;
    int          ofs;
    cur_test = "subword";
    for (int r = 0; r < 2; r++) begin
      // Word 10 is bufferable and word 200 is not
      base = (r == 0) ? 32'h0000_0028 : 32'h0000_0320;
      for (ofs = 0; ofs < 4; ofs++) begin
        issue(1'b1, LSU_BYTE, base + 32'(ofs), $random(seed));
        issue(1'b0, LSU_WORD, base, 32'h0);
      end
      for (ofs = 0; ofs < 4; ofs += 2) begin
        issue(1'b1, LSU_HALF, base + 32'(ofs), $random(seed));
        issue(1'b0, LSU_WORD, base, 32'h0);
      end
    end
    wait_idle();
  endtask

  task automatic buffer_under_stall();
    cur_test = "buffer_stall";
    // One store in the buffer plus one in the stage
    offer_under_stall(32'h0000_0100, 2);
    // Unbufferable stores get no further than the stage
    offer_under_stall(32'h0000_0300, 1);
  endtask

  task automatic store_load_ordering();
    cur_test   = "ordering";
    stall_done = 1'b0;
    fork
      drive_stall(1'b0);
      begin
        for (int k = 0; k < 8; k++) begin
          issue(1'b1, LSU_WORD, 32'(4 * (20 + k)), $random(seed));
          issue(1'b0, LSU_WORD, 32'(4 * (20 + k)), 32'h0);
        end
        stall_done = 1'b1;
      end
    join
    wait_idle();
  endtask

  task automatic random_access();
    logic      we;
    lsu_size_e size;
    int        word;
    int        ofs;
    word = $random(seed) & 255;
    we   = ($random(seed) & 1) != 0;
    case ($random(seed) & 3)
      0: begin
        size = LSU_BYTE;
        ofs  = $random(seed) & 3;
      end
      1: begin
        size = LSU_HALF;
        ofs  = $random(seed) & 2;
      end
      default: begin
        size = LSU_WORD;
        ofs  = 0;
      end
    endcase
    issue(we, size, 32'(word * 4 + ofs), $random(seed));
  endtask

  task automatic streaming_mix();
    cur_test = "streaming";
    // About one stalled cycle in four
    for (int i = 0; i < 4; i++) begin
      stall_pattern[32*i +: 32] = $random(seed) & $random(seed);
    end
    stall_done = 1'b0;
    fork
      drive_stall(1'b1);
      begin
        repeat (60) random_access();
        stall_done = 1'b1;
      end
    join
    wait_idle();
  endtask

  initial begin
    rst_n        = 1'b0;
    core_valid_i = 1'b0;
    core_req_i   = '0;
    mem_stall_i  = 1'b0;
    stall_done   = 1'b0;
    cur_test     = "reset";
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    word_roundtrip();
    subword_stores();
    buffer_under_stall();
    store_load_ordering();
    streaming_mix();
    // A duplicate response would show one cycle after the last one
    cur_test = "drain";
    repeat (2) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: sim.f
design/obi_pkg.sv
design/lsu_req_stage.sv
design/write_buffer.sv
design/data_mem.sv
design/data_port_top.sv
sim/write_buffer_sva.sv
sim/tb_data_port.sv

// File: Makefile
# Verilator build and run of the data port testbench
TOP := tb_data_port

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
